/* project.f */
+incdir+rtl
rtl/tlb_pkg.sv
rtl/tlb_entry_ram.sv
rtl/tlb_check_ram.sv
rtl/tlb_search_ctrl.sv
rtl/tlb_cfg_regs.sv
rtl/tlb_l2_top.sv
testbench/tb_tlb_l2.sv

/* rtl/tlb_cfg_regs.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_cfg_regs (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   wr_en_i,
   input  tlb_pkg::tlb_wr_t       wr_i,
   input  logic                   busy_i,
   input  logic                   req_valid_i,
   output logic                   ram_we_o,
   output logic [`TLB_RAM_AW-1:0] ram_addr_o,
   output logic [31:0]            ram_wdata_o,
   input  logic                   done_i,
   input  tlb_pkg::tlb_result_t   result_i,
   input  logic                   stats_clr_i,
   output tlb_pkg::tlb_stats_t    stats_o
);

   tlb_pkg::tlb_stats_t stats_q;

   // Writes only while idle and no lookup starting
   assign ram_we_o    = wr_en_i && !busy_i && !req_valid_i;
   assign ram_addr_o  = wr_i.idx;
   assign ram_wdata_o = wr_i.word.raw;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         stats_q <= '0;
      end else if (stats_clr_i) begin
         stats_q <= '0;  // Clear beats a pending count
      end else if (done_i) begin
         if (result_i.hit) begin
            stats_q.hit_cnt <= stats_q.hit_cnt + 1'b1;
         end
         if (result_i.miss) begin
            stats_q.miss_cnt <= stats_q.miss_cnt + 1'b1;
         end
         if (result_i.prot) begin
            stats_q.prot_cnt <= stats_q.prot_cnt + 1'b1;
         end
      end
   end

   assign stats_o = stats_q;

endmodule

/* rtl/tlb_check_ram.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_check_ram (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  tlb_pkg::tlb_req_t            lookup_i,
   input  logic [`TLB_RAM_AW-1:0]       port0_addr_i,
   input  logic [`TLB_RAM_AW-1:0]       port1_addr_i,
   input  logic [31:0]                  rdata0_i,
   input  logic [31:0]                  rdata1_i,
   input  logic                         searching_i,
   input  logic [`TLB_OFFSET_WIDTH-1:0] offset_d_i,
   input  logic                         send_outputs_i,
   output logic                         hit_o,
   output logic                         multi_hit_o,
   output logic                         prot_o,
   output logic [`TLB_RAM_AW-1:0]       hit_addr_o
);

   typedef enum logic {SEARCH, HIT} hit_state_t;

   tlb_pkg::tlb_word_u                        word0;
   tlb_pkg::tlb_word_u                        word1;
   logic [`TLB_ADDR_WIDTH-`TLB_PAGE_BITS-1:0] page;
   logic                                      port0_hit;
   logic                                      port1_hit;
   logic                                      port0_deny;
   logic                                      port1_deny;
   hit_state_t                                state_q;
   hit_state_t                                state_d;

   assign word0.raw = rdata0_i;
   assign word1.raw = rdata1_i;

   assign page = lookup_i.addr[`TLB_ADDR_WIDTH-1:`TLB_PAGE_BITS];

   // Valid entry with matching page number
   assign port0_hit = word0.entry.valid && (word0.entry.vpn == page);
   assign port1_hit = word1.entry.valid && (word1.entry.vpn == page);

   // Missing permission for the access type
   assign port0_deny = lookup_i.rw ? !word0.entry.wr : !word0.entry.rd;
   assign port1_deny = lookup_i.rw ? !word1.entry.wr : !word1.entry.rd;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= SEARCH;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d    = state_q;
      hit_o      = 1'b0;
      hit_addr_o = '0;
      unique case (state_q)
         SEARCH: begin
            if (searching_i && (port0_hit || port1_hit)) begin
               state_d = HIT;
               hit_o   = 1'b1;
               // Set and half from the port, offset from the delayed counter
               if (port0_hit) begin
                  hit_addr_o = {port0_addr_i[`TLB_RAM_AW-1:`TLB_OFFSET_WIDTH], offset_d_i};
               end else begin
                  hit_addr_o = {port1_addr_i[`TLB_RAM_AW-1:`TLB_OFFSET_WIDTH], offset_d_i};
               end
            end
         end
         HIT: begin
            if (send_outputs_i) begin
               state_d = SEARCH;  // Result taken by controller
            end
         end
         default: state_d = SEARCH;
      endcase
   end

   // Half 0 decides the fault when both match
   always_comb begin
      prot_o = 1'b0;
      if (searching_i && port0_hit) begin
         prot_o = port0_deny;
      end else if (searching_i && port1_hit) begin
         prot_o = port1_deny;
      end
   end

   assign multi_hit_o = searching_i && port0_hit && port1_hit;

endmodule

/* rtl/tlb_defines.svh */
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// Lookup address width
`define TLB_ADDR_WIDTH 32

// Page offset bits, not part of the compare
`define TLB_PAGE_BITS 12

// Set index, lowest page number bits
`define TLB_SET_WIDTH 5

// Entries per half as log2
`define TLB_OFFSET_WIDTH 4

// Set + half bit + offset
`define TLB_RAM_AW 10

// Statistics counter width
`define TLB_CNT_WIDTH 16

`endif

/* rtl/tlb_entry_ram.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_entry_ram (
   input  logic                   clk_i,
   input  logic                   we_i,
   input  logic [`TLB_RAM_AW-1:0] addr0_i,
   input  logic [`TLB_RAM_AW-1:0] addr1_i,
   input  logic [31:0]            wdata_i,
   output logic [31:0]            rdata0_o,
   output logic [31:0]            rdata1_o
);

   // Half 0 and half 1 of every set share this array
   logic [31:0] mem [0:(1<<`TLB_RAM_AW)-1];

   // Port 0 is read/write, old data on a same-address write
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr0_i] <= wdata_i;
      end
      rdata0_o <= mem[addr0_i];
   end

   // Port 1 only reads
   always_ff @(posedge clk_i) begin
      rdata1_o <= mem[addr1_i];
   end

endmodule

/* rtl/tlb_l2_top.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_l2_top (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  logic                 req_valid_i,
   input  tlb_pkg::tlb_req_t    req_i,
   input  logic                 wr_en_i,
   input  tlb_pkg::tlb_wr_t     wr_i,
   input  logic                 stats_clr_i,
   output logic                 busy_o,
   output logic                 done_o,
   output tlb_pkg::tlb_result_t result_o,
   output tlb_pkg::tlb_stats_t  stats_o
);

   tlb_pkg::tlb_req_t            lookup;
   logic [`TLB_RAM_AW-1:0]       srch_addr0;
   logic [`TLB_RAM_AW-1:0]       srch_addr1;
   logic [`TLB_RAM_AW-1:0]       cfg_addr;
   logic [`TLB_RAM_AW-1:0]       ram_addr0;
   logic [`TLB_RAM_AW-1:0]       hit_addr;
   logic [`TLB_OFFSET_WIDTH-1:0] offset_d;
   logic [31:0]                  ram_wdata;
   logic [31:0]                  rdata0;
   logic [31:0]                  rdata1;
   logic                         ram_we;
   logic                         searching;
   logic                         send_outputs;
   logic                         hit;
   logic                         multi_hit;
   logic                         prot;

   // Config write takes port 0 when enabled
   assign ram_addr0 = ram_we ? cfg_addr : srch_addr0;

   tlb_search_ctrl u_search_ctrl (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_valid_i    (req_valid_i),
      .req_i          (req_i),
      .hit_i          (hit),
      .multi_hit_i    (multi_hit),
      .prot_i         (prot),
      .hit_addr_i     (hit_addr),
      .lookup_o       (lookup),
      .port0_addr_o   (srch_addr0),
      .port1_addr_o   (srch_addr1),
      .searching_o    (searching),
      .offset_d_o     (offset_d),
      .send_outputs_o (send_outputs),
      .busy_o         (busy_o),
      .done_o         (done_o),
      .result_o       (result_o)
   );

   tlb_check_ram u_check_ram (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .lookup_i       (lookup),
      .port0_addr_i   (ram_addr0),
      .port1_addr_i   (srch_addr1),
      .rdata0_i       (rdata0),
      .rdata1_i       (rdata1),
      .searching_i    (searching),
      .offset_d_i     (offset_d),
      .send_outputs_i (send_outputs),
      .hit_o          (hit),
      .multi_hit_o    (multi_hit),
      .prot_o         (prot),
      .hit_addr_o     (hit_addr)
   );

   tlb_entry_ram u_entry_ram (
      .clk_i    (clk_i),
      .we_i     (ram_we),
      .addr0_i  (ram_addr0),
      .addr1_i  (srch_addr1),
      .wdata_i  (ram_wdata),
      .rdata0_o (rdata0),
      .rdata1_o (rdata1)
   );

   tlb_cfg_regs u_cfg_regs (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .wr_en_i     (wr_en_i),
      .wr_i        (wr_i),
      .busy_i      (busy_o),
      .req_valid_i (req_valid_i),
      .ram_we_o    (ram_we),
      .ram_addr_o  (cfg_addr),
      .ram_wdata_o (ram_wdata),
      .done_i      (done_o),
      .result_i    (result_o),
      .stats_clr_i (stats_clr_i),
      .stats_o     (stats_o)
   );

endmodule

/* rtl/tlb_pkg.sv */
`include "tlb_defines.svh"

package tlb_pkg;

   // Entry word as stored in the RAM
   typedef struct packed {
      logic [7:0]                                 rsvd;
      logic [`TLB_ADDR_WIDTH-`TLB_PAGE_BITS-1:0] vpn;    // Bits 23..4
      logic                                       unused;
      logic                                       wr;     // Write allowed
      logic                                       rd;     // Read allowed
      logic                                       valid;
   } tlb_entry_t;

   // Raw word on the config side, fields on the compare side
   typedef union packed {
      logic [31:0] raw;
      tlb_entry_t  entry;
   } tlb_word_u;

   typedef struct packed {
      logic [`TLB_ADDR_WIDTH-1:0] addr;
      logic                       rw;  // 1 = write
   } tlb_req_t;

   typedef struct packed {
      logic [`TLB_RAM_AW-1:0] idx;
      tlb_word_u              word;
   } tlb_wr_t;

   typedef struct packed {
      logic                   hit;
      logic                   miss;
      logic                   multi_hit;
      logic                   prot;
      logic [`TLB_RAM_AW-1:0] hit_addr;
   } tlb_result_t;

   typedef struct packed {
      logic [`TLB_CNT_WIDTH-1:0] hit_cnt;
      logic [`TLB_CNT_WIDTH-1:0] miss_cnt;
      logic [`TLB_CNT_WIDTH-1:0] prot_cnt;
   } tlb_stats_t;

endpackage

/* rtl/tlb_search_ctrl.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_search_ctrl (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  logic                         req_valid_i,
   input  tlb_pkg::tlb_req_t            req_i,
   input  logic                         hit_i,
   input  logic                         multi_hit_i,
   input  logic                         prot_i,
   input  logic [`TLB_RAM_AW-1:0]       hit_addr_i,
   output tlb_pkg::tlb_req_t            lookup_o,
   output logic [`TLB_RAM_AW-1:0]       port0_addr_o,
   output logic [`TLB_RAM_AW-1:0]       port1_addr_o,
   output logic                         searching_o,
   output logic [`TLB_OFFSET_WIDTH-1:0] offset_d_o,
   output logic                         send_outputs_o,
   output logic                         busy_o,
   output logic                         done_o,
   output tlb_pkg::tlb_result_t         result_o
);

   tlb_pkg::tlb_req_t             lookup_q;
   tlb_pkg::tlb_result_t          result_d;
   tlb_pkg::tlb_result_t          result_q;
   logic [`TLB_SET_WIDTH-1:0]     set_idx;
   logic [`TLB_OFFSET_WIDTH-1:0]  offset_q;    // Offset being issued
   logic [`TLB_OFFSET_WIDTH-1:0]  offset_d_q;  // Offset being compared
   logic                          busy_q;
   logic                          issue_q;     // RAM read strobe
   logic                          searching_q;
   logic                          done_q;
   logic                          accept;
   logic                          stop_hit;
   logic                          last_miss;

   assign accept    = req_valid_i && !busy_q;
   assign stop_hit  = searching_q && hit_i;
   assign last_miss = searching_q && !hit_i && (&offset_d_q);

   // Set comes from the lowest page number bits
   assign set_idx = lookup_q.addr[`TLB_PAGE_BITS +: `TLB_SET_WIDTH];

   assign port0_addr_o = {set_idx, 1'b0, offset_q};
   assign port1_addr_o = {set_idx, 1'b1, offset_q};

   // Request payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         lookup_q <= req_i;
      end
   end

   // Result of the compare cycle, registered below
   always_comb begin
      result_d = '0;
      if (stop_hit) begin
         result_d.hit       = 1'b1;
         result_d.multi_hit = multi_hit_i;
         result_d.prot      = prot_i;
         result_d.hit_addr  = hit_addr_i;
      end else if (last_miss) begin
         result_d.miss = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         busy_q      <= 1'b0;
         issue_q     <= 1'b0;
         searching_q <= 1'b0;
         done_q      <= 1'b0;
         offset_q    <= '0;
         offset_d_q  <= '0;
         result_q    <= '0;
      end else begin
         // One cycle behind the issue side, matches RAM latency
         searching_q <= issue_q && !stop_hit;
         offset_d_q  <= offset_q;
         done_q      <= stop_hit || last_miss;
         result_q    <= result_d;  // Zero outside the done cycle

         if (accept) begin
            busy_q   <= 1'b1;
            issue_q  <= 1'b1;
            offset_q <= '0;
         end else begin
            if (done_q) begin
               busy_q <= 1'b0;
            end
            if (stop_hit || (issue_q && (&offset_q))) begin
               issue_q <= 1'b0;  // Hit seen or set exhausted
            end else if (issue_q) begin
               offset_q <= offset_q + 1'b1;
            end
         end
      end
   end

   assign lookup_o       = lookup_q;
   assign searching_o    = searching_q;
   assign offset_d_o     = offset_d_q;
   assign send_outputs_o = done_q;
   assign busy_o         = busy_q;
   assign done_o         = done_q;
   assign result_o       = result_q;

endmodule

/* testbench/tb_tlb_l2.sv */
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tb_tlb_l2;

   localparam int PW = `TLB_ADDR_WIDTH - `TLB_PAGE_BITS;

   logic                 clk_i;
   logic                 rst_ni;
   logic                 req_valid_i;
   tlb_pkg::tlb_req_t    req_i;
   logic                 wr_en_i;
   tlb_pkg::tlb_wr_t     wr_i;
   logic                 stats_clr_i;
   logic                 busy_o;
   logic                 done_o;
   tlb_pkg::tlb_result_t result_o;
   tlb_pkg::tlb_stats_t  stats_o;

   logic [31:0] ref_mem [0:(1<<`TLB_RAM_AW)-1];  // Mirror of accepted writes
   logic [31:0] rng;
   int          err_cnt = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          lookup_cnt = 0;
   int          mdl_hits = 0;
   int          mdl_misses = 0;
   int          mdl_faults = 0;

   tlb_l2_top u_tlb_l2_top (.*);

   always #5 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Entry word: vpn in 23..4, write, read, valid in the low bits
   function automatic logic [31:0] make_entry(input logic [PW-1:0] vpn, input logic wr,
                                              input logic rd, input logic valid);
      return {8'h00, vpn, 1'b0, wr, rd, valid};
   endfunction

   // Reference search, half 0 before half 1 at each offset
   function automatic tlb_pkg::tlb_result_t predict(input logic [31:0] addr, input logic rw);
      tlb_pkg::tlb_result_t res;
      logic [PW-1:0]        page;
      logic [31:0]          e0;
      logic [31:0]          e1;
      logic [31:0]          e;
      logic                 h0;
      logic                 h1;
      res  = '0;
      page = addr[31:12];
      for (int off = 0; off < 16; off++) begin
         e0 = ref_mem[{page[4:0], 1'b0, off[3:0]}];
         e1 = ref_mem[{page[4:0], 1'b1, off[3:0]}];
         h0 = e0[0] && (e0[23:4] == page);
         h1 = e1[0] && (e1[23:4] == page);
         if (h0 || h1) begin
            e             = h0 ? e0 : e1;
            res.hit       = 1'b1;
            res.multi_hit = h0 && h1;
            res.prot      = rw ? !e[2] : !e[1];
            res.hit_addr  = {page[4:0], !h0, off[3:0]};
            return res;
         end
      end
      res.miss = 1'b1;
      return res;
   endfunction

   task automatic expect_eq(input string test, input string field, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (act === exp) else begin
         $display("Error: %s %s expected %h actual %h", test, field, exp, act);
         err_cnt++;
      end
   endtask

   task automatic write_entry(input logic [`TLB_RAM_AW-1:0] idx, input logic [31:0] word);
      wr_en_i          = 1'b1;
      wr_i.idx         = idx;
      wr_i.word.raw    = word;
      @(posedge clk_i);
      #1 wr_en_i       = 1'b0;
      ref_mem[idx]     = word;
   endtask

   task automatic issue_req(input logic [31:0] addr, input logic rw);
      req_valid_i = 1'b1;
      req_i       = {addr, rw};
      lookup_cnt++;
      @(posedge clk_i);
      #1 req_valid_i = 1'b0;
   endtask

   task automatic wait_done();
      while (!done_o) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic check_result(input string test, input tlb_pkg::tlb_result_t exp);
      expect_eq(test, "hit", exp.hit, result_o.hit);
      expect_eq(test, "miss", exp.miss, result_o.miss);
      expect_eq(test, "multi_hit", exp.multi_hit, result_o.multi_hit);
      expect_eq(test, "prot", exp.prot, result_o.prot);
      expect_eq(test, "hit_addr", exp.hit_addr, result_o.hit_addr);
      mdl_hits   += exp.hit;
      mdl_misses += exp.miss;
      mdl_faults += exp.prot;
      @(posedge clk_i);  // busy_o drops here
      #1;
      expect_eq(test, "done_o after pulse", 0, done_o);
      expect_eq(test, "busy_o after done", 0, busy_o);
      expect_eq(test, "result_o after done", 0, result_o);
   endtask

   task automatic run_lookup(input string test, input logic [31:0] addr, input logic rw);
      tlb_pkg::tlb_result_t exp;
      exp = predict(addr, rw);
      issue_req(addr, rw);
      wait_done();
      check_result(test, exp);
   endtask

   task automatic check_stats(input string test);
      expect_eq(test, "hit_cnt", mdl_hits, stats_o.hit_cnt);
      expect_eq(test, "miss_cnt", mdl_misses, stats_o.miss_cnt);
      expect_eq(test, "prot_cnt", mdl_faults, stats_o.prot_cnt);
   endtask

   task automatic report_test(input string test, input int start_err);
      tests_run++;
      if (err_cnt == start_err) begin
         $display("%s: ok", test);
      end else begin
         tests_failed++;
         $display("%s: FAILED with %0d errors", test, err_cnt - start_err);
      end
   endtask

   task automatic test_reset();
      int start_err;
      start_err = err_cnt;
      expect_eq("reset", "busy_o", 0, busy_o);
      expect_eq("reset", "done_o", 0, done_o);
      expect_eq("reset", "result_o", 0, result_o);
      check_stats("reset");
      for (int i = 0; i < (1 << `TLB_RAM_AW); i++) begin
         write_entry(i[`TLB_RAM_AW-1:0], 32'h0);  // Known contents for the model
      end
      report_test("reset", start_err);
   endtask

   task automatic test_hit_miss();
      int start_err;
      start_err = err_cnt;
      write_entry({5'd5, 1'b0, 4'd2}, make_entry({15'h0a1c, 5'd5}, 1, 1, 1));
      write_entry({5'd5, 1'b1, 4'd6}, make_entry({15'h0b2d, 5'd5}, 1, 1, 1));
      write_entry({5'd5, 1'b0, 4'd9}, make_entry({15'h0c3e, 5'd5}, 1, 1, 1));
      write_entry({5'd5, 1'b1, 4'd11}, make_entry({15'h0d4f, 5'd5}, 1, 1, 0));  // Invalid
      run_lookup("hit_miss", {15'h0a1c, 5'd5, 12'h3f0}, 1'b0);
      run_lookup("hit_miss", {15'h0b2d, 5'd5, 12'h004}, 1'b1);
      run_lookup("hit_miss", {15'h0c3e, 5'd5, 12'hfff}, 1'b0);
      run_lookup("hit_miss", {15'h0777, 5'd5, 12'h100}, 1'b0);
      run_lookup("hit_miss", {15'h0d4f, 5'd5, 12'h100}, 1'b0);
      report_test("hit_miss", start_err);
   endtask

   task automatic test_prot();
      int start_err;
      start_err = err_cnt;
      for (int c = 0; c < 4; c++) begin
         write_entry({5'd9, c[0], c[3:0]},
                     make_entry({15'h0200 + c[14:0], 5'd9}, c[1], c[0], 1));
      end
      for (int c = 0; c < 4; c++) begin
         run_lookup("prot", {15'h0200 + c[14:0], 5'd9, 12'h080}, 1'b0);
         run_lookup("prot", {15'h0200 + c[14:0], 5'd9, 12'h080}, 1'b1);
      end
      report_test("prot", start_err);
   endtask

   task automatic test_multi_hit();
      int start_err;
      start_err = err_cnt;
      write_entry({5'd17, 1'b0, 4'd4}, make_entry({15'h4444, 5'd17}, 1, 1, 1));
      write_entry({5'd17, 1'b1, 4'd4}, make_entry({15'h4444, 5'd17}, 0, 1, 1));
      write_entry({5'd17, 1'b0, 4'd7}, make_entry({15'h5555, 5'd17}, 1, 0, 1));
      write_entry({5'd17, 1'b1, 4'd3}, make_entry({15'h5555, 5'd17}, 1, 1, 1));
      run_lookup("multi_hit", {15'h4444, 5'd17, 12'h000}, 1'b1);
      run_lookup("multi_hit", {15'h5555, 5'd17, 12'h000}, 1'b0);
      report_test("multi_hit", start_err);
   endtask

   task automatic test_busy_write_clear();
      tlb_pkg::tlb_result_t exp;
      int                   start_err;
      start_err = err_cnt;
      exp = predict({15'h0777, 5'd22, 12'h000}, 1'b0);
      issue_req({15'h0777, 5'd22, 12'h000}, 1'b0);
      assert (busy_o) else begin
         $display("busy_o stayed low after a lookup was requested");
         err_cnt++;
      end
      wr_en_i       = 1'b1;  // Must be dropped, ref_mem untouched
      wr_i.idx      = {5'd22, 1'b0, 4'd0};
      wr_i.word.raw = make_entry({15'h0333, 5'd22}, 1, 1, 1);
      @(posedge clk_i);
      #1 wr_en_i    = 1'b0;
      wait_done();
      check_result("busy_write", exp);
      run_lookup("busy_write", {15'h0333, 5'd22, 12'h000}, 1'b0);
      stats_clr_i = 1'b1;
      @(posedge clk_i);
      #1 stats_clr_i = 1'b0;
      mdl_hits   = 0;
      mdl_misses = 0;
      mdl_faults = 0;
      check_stats("busy_write");
      report_test("busy_write", start_err);
   endtask

   task automatic test_random();
      logic [PW-1:0] page;
      int            start_err;
      start_err = err_cnt;
      for (int n = 0; n < 60; n++) begin
         // Small page pool in sets 0 to 3 so lookups collide
         rng  = xorshift32(rng);
         page = {13'h1a5, rng[9:8], 3'b000, rng[1:0]};
         write_entry({page[4:0], rng[10], rng[14:11]},
                     make_entry(page, rng[18], rng[17], rng[15] | rng[16]));
         rng  = xorshift32(rng);
         page = {13'h1a5, rng[9:8], 3'b000, rng[1:0]};
         run_lookup("random", {page, rng[31:20]}, rng[19]);
      end
      check_stats("random");
      report_test("random", start_err);
   endtask

   // Watchdog, budget grows with each lookup issued
   initial begin
      int cycles;
      cycles = 0;
      while (cycles <= 200 * lookup_cnt + 2000) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Watchdog expired after %0d cycles, the tests did not finish", cycles);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      clk_i       = 1'b0;
      rst_ni      = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      wr_en_i     = 1'b0;
      wr_i        = '0;
      stats_clr_i = 1'b0;
      rng         = 32'hc7a8_094f;
      repeat (3) @(posedge clk_i);
      #1 rst_ni   = 1'b1;
      test_reset();
      test_hit_miss();
      test_prot();
      test_multi_hit();
      test_busy_write_clear();
      test_random();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
